// File: common/wfd_config.svh
`ifndef WFD_CONFIG_SVH
`define WFD_CONFIG_SVH

//////////////////////////////////////////////////
// datapath widths
//////////////////////////////////////////////////
`define WFD_LINK_W          32   // one word on the serial link
`define WFD_BURST_W         128  // one memory burst
`define WFD_WORDS_PER_BURST 4    // link words per burst

//////////////////////////////////////////////////
// timing and sizing
//////////////////////////////////////////////////
`define WFD_LONG_RST_CYCLES 16   // synced high cycles that make a master reset "long"
`define WFD_FIFO_DEPTH_LOG2 4    // 16 entries per stream fifo
`define WFD_SYNC_STAGES     2    // flops in each async input synchronizer

`endif

// File: common/wfd_pkg.sv
`include "wfd_config.svh"

package wfd_pkg;

  // raw payloads
  typedef logic [`WFD_LINK_W-1:0]  link_word_t;  // word to or from the link
  typedef logic [`WFD_BURST_W-1:0] burst_t;      // one memory burst

  // command word plus its packet end flag
  typedef struct packed {
    link_word_t data;
    logic       last;  // final word of a command packet
  } cmd_item_t;

  // memory burst plus its fill end flag
  typedef struct packed {
    burst_t data;
    logic   last;      // final burst of a fill
  } burst_item_t;

  // counter for the master reset length, saturates at the long threshold
  typedef logic [$clog2(`WFD_LONG_RST_CYCLES+1)-1:0] rst_cnt_t;

endpackage

// File: readout/burst_width_converter.sv
`timescale 1ns/100ps
`include "wfd_config.svh"

module burst_width_converter import wfd_pkg::*; (
  input  logic        clk125,
  input  logic        rst,
  input  burst_item_t burst_item,
  input  logic        burst_valid,
  output logic        burst_ready,
  output link_word_t  word_tdata,
  output logic        word_tvalid,
  output logic        word_tlast,
  input  logic        word_tready
);

  localparam int WPB   = `WFD_WORDS_PER_BURST;
  localparam int IDX_W = $clog2(WPB);

  burst_t           shift_q;   // remaining words, lsw at the bottom
  logic             last_q;    // burst closes the fill
  logic             holding;   // a burst is in flight
  logic [IDX_W-1:0] idx;       // word now presented
  logic             final_word;

  assign burst_ready = ~holding;  // one burst at a time
  assign word_tvalid = holding;
  assign word_tdata  = shift_q[`WFD_LINK_W-1:0];
  assign final_word  = (idx == IDX_W'(WPB - 1));
  assign word_tlast  = holding & last_q & final_word;  // only on word 3 of a flagged burst

  //////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////
  always_ff @(posedge clk125) begin
    if (rst) begin
      holding <= 1'b0;
      idx     <= '0;
    end else if (burst_valid & burst_ready) begin
      holding <= 1'b1;
      idx     <= '0;
    end else if (word_tvalid & word_tready) begin
      if (final_word)
        holding <= 1'b0;  // free for the next burst
      else
        idx <= idx + 1'b1;
    end
  end

  // payload
  always_ff @(posedge clk125) begin
    if (burst_valid & burst_ready) begin
      shift_q <= burst_item.data;
      last_q  <= burst_item.last;
    end else if (word_tvalid & word_tready) begin
      shift_q <= shift_q >> `WFD_LINK_W;  // next word down
    end
  end

endmodule

// File: readout/stream_fifo.sv
`timescale 1ns/100ps
`include "wfd_config.svh"

module stream_fifo import wfd_pkg::*; #(
  parameter type item_t = cmd_item_t
) (
  input  logic  clk125,
  input  logic  rst,
  input  item_t in_item,
  input  logic  in_valid,
  output logic  in_ready,   // registered, low when the buffer is full
  output item_t out_item,   // registered output stage
  output logic  out_valid,
  input  logic  out_ready
);

  localparam int AW    = `WFD_FIFO_DEPTH_LOG2;
  localparam int DEPTH = 1 << AW;

  item_t           mem [DEPTH];  // circular buffer
  logic [AW-1:0]   wr_ptr;
  logic [AW-1:0]   rd_ptr;
  logic [AW:0]     count;        // entries held in mem, output stage excluded
  logic [AW:0]     count_next;
  logic            wr_en;        // input transfer
  logic            load;         // output stage free or being emptied
  logic            mem_rd;       // output stage refilled from mem
  logic            mem_wr;       // input lands in mem, not bypassed

  assign wr_en  = in_valid & in_ready;
  assign load   = ~out_valid | out_ready;
  assign mem_rd = load & (count != '0);
  assign mem_wr = wr_en & ~(load & (count == '0));  // empty and free -> straight to output

  always_comb begin
    count_next = count;
    if (mem_wr & ~mem_rd)
      count_next = count + 1'b1;
    else if (mem_rd & ~mem_wr)
      count_next = count - 1'b1;
  end

  //////////////////////////////////////////////////
  // pointers, occupancy, output valid
  //////////////////////////////////////////////////
  always_ff @(posedge clk125) begin
    if (rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      out_valid <= 1'b0;
      in_ready  <= 1'b0;  // comes up one cycle after reset
    end else begin
      count    <= count_next;
      in_ready <= (count_next != (AW+1)'(DEPTH));
      if (mem_wr)
        wr_ptr <= wr_ptr + 1'b1;
      if (mem_rd)
        rd_ptr <= rd_ptr + 1'b1;
      if (load)
        out_valid <= mem_rd | wr_en;
    end
  end

  // payload, no reset
  always_ff @(posedge clk125) begin
    if (mem_wr)
      mem[wr_ptr] <= in_item;
    if (mem_rd)
      out_item <= mem[rd_ptr];
    else if (load & wr_en)
      out_item <= in_item;  // bypass while empty
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the channel readout testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_channel_readout -f wfd_readout.f -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error, see sim.log"
  exit 1
fi

if grep -qx "NO ERRORS" sim.log; then
  echo "PASS"
  exit 0
fi
echo "FAIL, see sim.log"
exit 1

// File: source/channel_readout_top.sv
`timescale 1ns/100ps

module channel_readout_top import wfd_pkg::*; (
  input  logic       clk125,
  input  logic       rst,
  input  logic       rst_from_master,
  input  logic       readout_pause,
  input  logic       readout_start,
  input  link_word_t cmd_tdata,
  input  logic       cmd_tvalid,
  input  logic       cmd_tlast,
  output logic       cmd_tready,
  input  burst_t     burst_tdata,
  input  logic       burst_tvalid,
  input  logic       burst_tlast,
  output logic       burst_tready,
  output link_word_t link_tdata,
  output logic       link_tvalid,
  output logic       link_tlast,
  input  logic       link_tready,
  output logic       readout_busy,
  output logic       evt_cnt_reset,
  output logic       full_reset
);

  logic        rst_path;      // readout path reset, local or from master
  cmd_item_t   cmd_in_item;
  cmd_item_t   cmd_q_item;
  logic        cmd_q_valid;
  logic        cmd_q_ready;
  burst_item_t burst_in_item;
  burst_item_t burst_q_item;
  logic        burst_q_valid;
  logic        burst_q_ready;
  link_word_t  ddr3_tdata;    // converter to mux
  logic        ddr3_tvalid;
  logic        ddr3_tlast;
  logic        ddr3_tready;

  assign rst_path      = rst | full_reset;
  assign cmd_in_item   = '{data: cmd_tdata, last: cmd_tlast};
  assign burst_in_item = '{data: burst_tdata, last: burst_tlast};

  master_reset u_master_reset (.clk125, .rst, .rst_from_master, .evt_cnt_reset, .full_reset);

  //////////////////////////////////////////////////
  // memory path
  //////////////////////////////////////////////////
  stream_fifo #(.item_t(burst_item_t)) u_burst_fifo (
    .clk125, .rst(rst_path),
    .in_item(burst_in_item), .in_valid(burst_tvalid), .in_ready(burst_tready),
    .out_item(burst_q_item), .out_valid(burst_q_valid), .out_ready(burst_q_ready));

  burst_width_converter u_conv (
    .clk125, .rst(rst_path),
    .burst_item(burst_q_item), .burst_valid(burst_q_valid), .burst_ready(burst_q_ready),
    .word_tdata(ddr3_tdata), .word_tvalid(ddr3_tvalid), .word_tlast(ddr3_tlast),
    .word_tready(ddr3_tready));

  // command path
  stream_fifo #(.item_t(cmd_item_t)) u_cmd_fifo (
    .clk125, .rst(rst_path),
    .in_item(cmd_in_item), .in_valid(cmd_tvalid), .in_ready(cmd_tready),
    .out_item(cmd_q_item), .out_valid(cmd_q_valid), .out_ready(cmd_q_ready));

  link_tx_mux u_mux (
    .clk125, .rst(rst_path), .readout_pause, .readout_start,
    .cmd_item(cmd_q_item), .cmd_valid(cmd_q_valid), .cmd_ready(cmd_q_ready),
    .ddr3_tdata, .ddr3_tvalid, .ddr3_tlast, .ddr3_tready,
    .link_tdata, .link_tvalid, .link_tlast, .link_tready, .readout_busy);

endmodule

// File: source/link_tx_mux.sv
`timescale 1ns/100ps
`include "wfd_config.svh"

module link_tx_mux import wfd_pkg::*; (
  input  logic       clk125,
  input  logic       rst,
  input  logic       readout_pause,  // async level, stalls the link
  input  logic       readout_start,  // strobe, switch to memory data
  input  cmd_item_t  cmd_item,
  input  logic       cmd_valid,
  output logic       cmd_ready,
  input  link_word_t ddr3_tdata,
  input  logic       ddr3_tvalid,
  input  logic       ddr3_tlast,
  output logic       ddr3_tready,
  output link_word_t link_tdata,
  output logic       link_tvalid,
  output logic       link_tlast,
  input  logic       link_tready,
  output logic       readout_busy    // memory source selected
);

  logic [`WFD_SYNC_STAGES-1:0] pause_q;  // pause synchronizer
  logic                        pause_s;
  logic                        use_ddr3;  // memory source selected
  logic                        cmd_open;  // command packet partway through
  logic                        go;        // link free to take a word
  logic                        cmd_xfer;
  logic                        ddr3_accept;  // link took a memory word

  assign pause_s = pause_q[`WFD_SYNC_STAGES-1];
  assign go      = link_tready & ~pause_s;

  //////////////////////////////////////////////////
  // 2:1 mux, combinational
  //////////////////////////////////////////////////
  assign link_tvalid = ~pause_s & (use_ddr3 ? ddr3_tvalid : cmd_valid);
  assign link_tlast  = use_ddr3 ? (ddr3_tvalid & ddr3_tlast) : (cmd_valid & cmd_item.last);
  assign link_tdata  = use_ddr3 ? ddr3_tdata : cmd_item.data;

  assign ddr3_tready = use_ddr3 & go;   // ready only to the active source
  assign cmd_ready   = ~use_ddr3 & go;

  assign cmd_xfer     = cmd_valid & cmd_ready;
  assign ddr3_accept  = ddr3_tvalid & ddr3_tready;
  assign readout_busy = use_ddr3;

  //////////////////////////////////////////////////
  // source selection
  //////////////////////////////////////////////////
  always_ff @(posedge clk125) begin
    if (rst) begin
      pause_q  <= '0;
      use_ddr3 <= 1'b0;
      cmd_open <= 1'b0;
    end else begin
      pause_q <= {pause_q[`WFD_SYNC_STAGES-2:0], readout_pause};
      if (cmd_xfer)
        cmd_open <= ~cmd_item.last;  // open until its last word goes
      // start only between command packets, ignored during a readout
      if (~use_ddr3) begin
        if (readout_start & ~cmd_open & ~(cmd_xfer & ~cmd_item.last))
          use_ddr3 <= 1'b1;
      end else if (ddr3_accept & ddr3_tlast) begin
        use_ddr3 <= 1'b0;  // fill done, back to commands
      end
    end
  end

endmodule

// File: source/master_reset.sv
`timescale 1ns/100ps
`include "wfd_config.svh"

module master_reset import wfd_pkg::*; (
  input  logic clk125,
  input  logic rst,
  input  logic rst_from_master,  // async level from the master fpga
  output logic evt_cnt_reset,    // short pulse seen, one cycle
  output logic full_reset        // long pulse seen, one cycle
);

  logic [`WFD_SYNC_STAGES-1:0] sync_q;  // input synchronizer chain
  logic                        sync_d;  // previous synced value, for edge detect
  rst_cnt_t                    hi_cnt;  // synced high cycles so far
  logic                        sync_s;

  assign sync_s = sync_q[`WFD_SYNC_STAGES-1];

  //////////////////////////////////////////////////
  // synchronize, count and sort by length
  //////////////////////////////////////////////////
  always_ff @(posedge clk125) begin
    if (rst) begin
      sync_q        <= '0;
      sync_d        <= 1'b0;
      hi_cnt        <= '0;
      evt_cnt_reset <= 1'b0;
      full_reset    <= 1'b0;
    end else begin
      sync_q <= {sync_q[`WFD_SYNC_STAGES-2:0], rst_from_master};
      sync_d <= sync_s;
      // count while high, hold at the threshold
      if (sync_s) begin
        if (hi_cnt != rst_cnt_t'(`WFD_LONG_RST_CYCLES))
          hi_cnt <= hi_cnt + 1'b1;
      end else begin
        hi_cnt <= '0;  // cleared on the edge after the fall is seen
      end
      // falling edge of a pulse that never got long
      evt_cnt_reset <= sync_d & ~sync_s &
                       (hi_cnt < rst_cnt_t'(`WFD_LONG_RST_CYCLES));
      // fires once, as the count reaches the threshold
      full_reset    <= sync_s & (hi_cnt == rst_cnt_t'(`WFD_LONG_RST_CYCLES - 1));
    end
  end

endmodule

// File: tb/readout_assertions.sv
`timescale 1ns/100ps

module readout_assertions import wfd_pkg::*; (
  input logic       clk125,
  input logic       rst,
  input logic       rst_from_master,
  input link_word_t link_tdata,
  input logic       link_tvalid,
  input logic       link_tlast,
  input logic       link_tready,
  input logic       readout_busy,
  input logic       evt_cnt_reset,
  input logic       full_reset
);

  logic master_d;    // rst_from_master at the last edge
  logic long_pulse;  // full_reset seen since rst_from_master last rose

  always_ff @(posedge clk125) begin
    if (rst) begin
      master_d   <= 1'b0;
      long_pulse <= 1'b0;
    end else begin
      master_d <= rst_from_master;
      if (full_reset)
        long_pulse <= 1'b1;
      else if (rst_from_master && !master_d)
        long_pulse <= 1'b0;  // a new master pulse begins
    end
  end

  //////////////////////////////////////////////////
  // link handshake
  //////////////////////////////////////////////////
  // a stalled word stays put unless valid drops or the source switches
  assert property (@(posedge clk125) disable iff (rst || full_reset)
    (link_tvalid && !link_tready) |=>
      (!link_tvalid || $changed(readout_busy) ||
       ($stable(link_tdata) && $stable(link_tlast))))
    else $error("link word changed while stalled");

  // reset outputs, a long pulse never also ends in a short one
  assert property (@(posedge clk125) disable iff (rst)
    !(evt_cnt_reset && (full_reset || long_pulse)))
    else $error("short master reset pulse reported for a long pulse");

  assert property (@(posedge clk125)
    rst |=> !(link_tvalid || readout_busy || evt_cnt_reset || full_reset))
    else $error("control output high right after reset");

endmodule

bind channel_readout_top readout_assertions u_assert (.*);

// File: tb/readout_checker.sv
`timescale 1ns/100ps
`include "wfd_config.svh"

module readout_checker import wfd_pkg::*; (
  input  logic       clk125,
  input  logic       rst,
  input  logic       readout_pause,
  input  logic       readout_start,
  input  link_word_t cmd_tdata,
  input  logic       cmd_tvalid,
  input  logic       cmd_tlast,
  input  logic       cmd_tready,
  input  burst_t     burst_tdata,
  input  logic       burst_tvalid,
  input  logic       burst_tlast,
  input  logic       burst_tready,
  input  link_word_t link_tdata,
  input  logic       link_tvalid,
  input  logic       link_tlast,
  input  logic       link_tready,
  input  logic       readout_busy,
  input  logic       evt_cnt_reset,
  input  logic       full_reset,
  output int         errors,
  output int         cmd_left,    // command words still expected
  output int         word_left,   // memory words still expected
  output int         evt_seen,
  output int         full_seen
);

  link_word_t cmd_q[$];
  logic       cmd_last_q[$];
  link_word_t word_q[$];
  logic       word_last_q[$];
  logic       pkt_open = 1'b0;  // model of an open command packet
  logic       mem_sel  = 1'b0;  // model of the selected source, memory when high
  logic       start_ok;         // start seen between packets, outside a readout
  logic       exp_last;
  int         pause_cnt = 0;   // sampled cycles with pause high

  initial begin
    errors = 0;
    cmd_left = 0;
    word_left = 0;
    evt_seen = 0;
    full_seen = 0;
  end

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("error %s: expected %h actual %h", name, exp, act);
    end
  endtask

  //////////////////////////////////////////////////
  // model, one step per clock edge
  //////////////////////////////////////////////////
  always @(posedge clk125) begin
    if (rst) begin
      cmd_q.delete();
      cmd_last_q.delete();
      word_q.delete();
      word_last_q.delete();
      pkt_open  = 1'b0;
      mem_sel   = 1'b0;
      pause_cnt = 0;
    end else begin
      pause_cnt = readout_pause ? pause_cnt + 1 : 0;
      if (pause_cnt > `WFD_SYNC_STAGES && link_tvalid) begin
        errors++;
        $display("link offered a word during a long pause");
      end
      compare("readout_busy", 32'(mem_sel), 32'(readout_busy));
      start_ok = readout_start && !mem_sel && !pkt_open;
      if (link_tvalid && link_tready) begin
        if (mem_sel) begin
          if (word_q.size() == 0) begin
            errors++;
            $display("memory word on the link with none expected");
          end else begin
            exp_last = word_last_q.pop_front();
            compare("burst_word", word_q.pop_front(), link_tdata);
            compare("burst_last", 32'(exp_last), 32'(link_tlast));
            if (exp_last)
              mem_sel = 1'b0;  // fill done, commands next cycle
          end
        end else if (cmd_q.size() == 0) begin
          errors++;
          $display("command word on the link with none expected");
        end else begin
          exp_last = cmd_last_q.pop_front();
          compare("cmd_word", cmd_q.pop_front(), link_tdata);
          compare("cmd_last", 32'(exp_last), 32'(link_tlast));
          pkt_open = !exp_last;
        end
      end
      if (start_ok && !pkt_open)  // a word opening a packet now blocks the start
        mem_sel = 1'b1;
      if (full_reset) begin  // path cleared, queued items are gone
        cmd_q.delete();
        cmd_last_q.delete();
        word_q.delete();
        word_last_q.delete();
        pkt_open  = 1'b0;
        mem_sel   = 1'b0;
        pause_cnt = 0;     // pause synchronizer restarts
      end else begin
        if (cmd_tvalid && cmd_tready) begin
          cmd_q.push_back(cmd_tdata);
          cmd_last_q.push_back(cmd_tlast);
        end
        if (burst_tvalid && burst_tready) begin
          for (int w = 0; w < `WFD_WORDS_PER_BURST; w++) begin
            word_q.push_back(burst_tdata[w*`WFD_LINK_W +: `WFD_LINK_W]);
            word_last_q.push_back(burst_tlast && (w == `WFD_WORDS_PER_BURST - 1));
          end
        end
      end
      if (evt_cnt_reset)
        evt_seen++;
      if (full_reset)
        full_seen++;
    end
    cmd_left  = cmd_q.size();
    word_left = word_q.size();
  end

endmodule

// File: tb/tb_channel_readout.sv
`timescale 1ns/100ps
`include "wfd_config.svh"

module tb_channel_readout import wfd_pkg::*; ();

  localparam int N_CMD_A = 20;   // command words, quiet link
  localparam int N_CMD_B = 150;  // command words, random traffic
  localparam int N_BURST = 60;
  localparam int STALL   = 40;   // worst cycles per link word, pauses included
  localparam int LIMIT   = (N_CMD_A + N_CMD_B + N_BURST * `WFD_WORDS_PER_BURST) * STALL + 4000;

  logic clk125 = 1'b0;
  logic rst, rst_from_master, readout_pause, readout_start;
  link_word_t cmd_tdata, link_tdata;
  logic cmd_tvalid, cmd_tlast, cmd_tready;
  burst_t burst_tdata;
  logic burst_tvalid, burst_tlast, burst_tready;
  logic link_tvalid, link_tlast, link_tready;
  logic readout_busy, evt_cnt_reset, full_reset;

  integer seed = 32'hbff2_528b;
  int tb_errors = 0;
  int chk_errors, cmd_left, word_left, evt_seen, full_seen;
  int cycles = 0;
  int cmd_sent = 0, cmd_target = 0, burst_sent = 0, burst_target = 0;
  int fill_left = 0, pause_left = 0, exp_evt = 0, exp_full = 0;
  bit gen_on = 0, rand_mode = 0, drain = 0;
  logic cmd_fired = 1'b0, burst_fired = 1'b0;  // transfer at the last edge

  always #2 clk125 = ~clk125;

  channel_readout_top uut (.*);

  readout_checker u_check (.*, .errors(chk_errors), .cmd_left, .word_left,
                           .evt_seen, .full_seen);

  function automatic int unsigned rnd(input int unsigned n);
    rnd = $unsigned($random(seed)) % n;
  endfunction

  task automatic finish_run(input bit timed_out);
    $display("errors: testbench %0d, checker %0d", tb_errors, chk_errors);
    if (tb_errors == 0 && chk_errors == 0 && !timed_out)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  endtask

  task automatic master_pulse(input int unsigned len);
    rst_from_master = 1'b1;
    repeat (len) @(negedge clk125);
    rst_from_master = 1'b0;
    repeat (12 + rnd(30)) @(negedge clk125);
  endtask

  always @(posedge clk125) begin
    cmd_fired   <= cmd_tvalid & cmd_tready;
    burst_fired <= burst_tvalid & burst_tready;
    cycles++;
    if (cycles >= LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      finish_run(1'b1);
    end
  end

  //////////////////////////////////////////////////
  // stimulus, all on the falling edge
  //////////////////////////////////////////////////
  always @(negedge clk125) begin
    if (gen_on) begin
      if (!cmd_tvalid || cmd_fired) begin  // hold until taken
        cmd_tvalid = 1'b0;
        if (cmd_sent < cmd_target && (!rand_mode || rnd(4) != 0)) begin
          cmd_tvalid = 1'b1;
          cmd_tdata  = $random(seed);
          cmd_tlast  = (cmd_sent == cmd_target - 1) || (rnd(4) == 0);
          cmd_sent++;
        end
      end
      if (!burst_tvalid || burst_fired) begin
        burst_tvalid = 1'b0;
        if (burst_sent < burst_target && rnd(3) != 0) begin
          if (fill_left == 0)
            fill_left = 1 + rnd(4);  // bursts in this fill
          burst_tvalid = 1'b1;
          burst_tdata  = {$random(seed), $random(seed), $random(seed), $random(seed)};
          burst_tlast  = (fill_left == 1) || (burst_sent == burst_target - 1);
          fill_left    = burst_tlast ? 0 : fill_left - 1;
          burst_sent++;
        end
      end
      link_tready = rand_mode ? (rnd(4) != 0) : 1'b1;
      if (pause_left > 0)
        pause_left--;
      else if (rand_mode && rnd(64) == 0)
        pause_left = 1 + rnd(30);
      readout_pause = (pause_left > 0);
      // start only with memory words waiting, or the mux would wait forever
      readout_start = rand_mode && word_left > 0 &&
                      (drain ? (!readout_busy && rnd(4) == 0) : (rnd(16) == 0));
    end
  end

  initial begin
    rst = 1'b1;
    rst_from_master = 1'b0;
    readout_pause = 1'b0;
    readout_start = 1'b0;
    cmd_tdata = '0;
    cmd_tvalid = 1'b0;
    cmd_tlast = 1'b0;
    burst_tdata = '0;
    burst_tvalid = 1'b0;
    burst_tlast = 1'b0;
    link_tready = 1'b0;
    repeat (3) @(negedge clk125);
    rst = 1'b0;
    if ({link_tvalid, link_tlast, readout_busy, evt_cnt_reset, full_reset,
         cmd_tready, burst_tready} !== 7'b0) begin
      tb_errors++;
      $display("error reset_outputs: expected %b actual %b", 7'b0,
               {link_tvalid, link_tlast, readout_busy, evt_cnt_reset, full_reset,
                cmd_tready, burst_tready});
    end
    // commands alone on a free link
    cmd_target = N_CMD_A;
    gen_on = 1;
    wait (cmd_sent == cmd_target && !cmd_tvalid && cmd_left == 0);
    // random traffic, readouts, pauses and master resets
    @(negedge clk125);
    cmd_target += N_CMD_B;
    burst_target = N_BURST;
    rand_mode = 1;
    repeat (50) @(negedge clk125);
    repeat (3) begin
      master_pulse(2 + rnd(9));
      exp_evt++;
    end
    repeat (2) begin
      master_pulse(`WFD_LONG_RST_CYCLES + 4 + rnd(21));
      exp_full++;
    end
    drain = 1;
    wait (cmd_sent == cmd_target && burst_sent == burst_target && !cmd_tvalid &&
          !burst_tvalid && cmd_left == 0 && word_left == 0 && !readout_busy);
    repeat (20) @(negedge clk125);
    if (evt_seen != exp_evt) begin
      tb_errors++;
      $display("error evt_cnt_reset_count: expected %0d actual %0d", exp_evt, evt_seen);
    end
    if (full_seen != exp_full) begin
      tb_errors++;
      $display("error full_reset_count: expected %0d actual %0d", exp_full, full_seen);
    end
    finish_run(1'b0);
  end

endmodule

// File: wfd_readout.f
+incdir+common
common/wfd_pkg.sv
source/master_reset.sv
readout/stream_fifo.sv
readout/burst_width_converter.sv
source/link_tx_mux.sv
source/channel_readout_top.sv
tb/readout_assertions.sv
tb/readout_checker.sv
tb/tb_channel_readout.sv
